// File: verilog/vcore_params.svh
////////////////////////////////////////
// vector core parameters
// opcodes, function codes and sizes
////////////////////////////////////////
`ifndef VCORE_PARAMS_SVH
`define VCORE_PARAMS_SVH

`define VC_LANES     4               // elements per vector
`define VC_NREGS     32              // vector registers
`define VC_QDEPTH    4               // queue depth, also initial credits

`define VC_OPC_ARITH 7'h57
`define VC_OPC_LOAD  7'h07
`define VC_OPC_STORE 7'h27
`define VC_OPC_CFG   7'h77

`define VC_F_ADD     4'd0
`define VC_F_SUB     4'd1
`define VC_F_MUL     4'd2           // low 32 bits of product
`define VC_F_AND     4'd3

`endif

// File: verilog/vcore_pkg.sv
////////////////////////////////////////
// vector core types
// element, vector, mask and instruction views
////////////////////////////////////////
`include "vcore_params.svh"

package vcore_pkg;

    typedef logic [31:0] elem_t;
    typedef elem_t [`VC_LANES-1:0] vreg_t;   // element i at bits 32i upward
    typedef logic [`VC_LANES-1:0] emask_t;
    typedef logic [4:0] vreg_addr_t;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        MUL = 4'd2,
        AND = 4'd3
    } vex_op_e;

    ////////////////////////////////////////
    // instruction word views

    typedef struct packed {
        logic [1:0]  rsvd_hi;
        logic [3:0]  funct;
        logic        use_imm;
        vreg_addr_t  vs2;
        vreg_addr_t  vs1;                    // or imm5
        logic [2:0]  rsvd_lo;
        vreg_addr_t  vd;
        logic [6:0]  opcode;
    } arith_view_t;

    typedef struct packed {
        logic [11:0] base;                   // byte address, word aligned
        logic [7:0]  rsvd;
        vreg_addr_t  vd;                     // data register
        logic [6:0]  opcode;
    } mem_view_t;

    typedef struct packed {
        logic [11:0] avl;
        logic [12:0] rsvd;
        logic [6:0]  opcode;
    } cfg_view_t;

    typedef union packed {
        arith_view_t arith;
        mem_view_t   mem;
        cfg_view_t   cfg;
    } inst_u;

endpackage

// File: verilog/inst_queue.sv
////////////////////////////////////////
// instruction queue
// small FIFO, one credit back per pop
////////////////////////////////////////
`timescale 1ns/1ns
`include "vcore_params.svh"

module inst_queue (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  vcore_pkg::inst_u  inst_i,
    input  logic              pop_i,
    output logic              empty_o,
    output vcore_pkg::inst_u  head_o,
    output logic              inst_credit_o
);
    import vcore_pkg::*;

    localparam int PW = $clog2(`VC_QDEPTH);

    inst_u         mem_q [`VC_QDEPTH];
    logic [PW:0]   wr_ptr_q;                 // extra bit tells full from empty
    logic [PW:0]   rd_ptr_q;
    logic          full;
    logic          push;
    logic          pop;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full    = (wr_ptr_q[PW] != rd_ptr_q[PW]) &&
                     (wr_ptr_q[PW-1:0] == rd_ptr_q[PW-1:0]);
    assign push    = inst_valid_i && !full;  // sender never overruns its credits
    assign pop     = pop_i && !empty_o;

    assign head_o        = mem_q[rd_ptr_q[PW-1:0]];
    assign inst_credit_o = pop;              // credit goes back with the pop

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q[PW-1:0]] <= inst_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

endmodule

// File: verilog/vcsrs.sv
////////////////////////////////////////
// vector config register
// holds vl and the element mask from it
////////////////////////////////////////
`timescale 1ns/1ns
`include "vcore_params.svh"

module vcsrs (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               cfg_we_i,
    input  logic [11:0]        avl_i,
    output logic [2:0]         vl_o,
    output vcore_pkg::emask_t  emask_o
);

    logic [2:0] vl_q;
    logic [2:0] vl_clamp;

    // vl = min(avl, lanes)
    assign vl_clamp = (avl_i > 12'(`VC_LANES)) ? 3'(`VC_LANES) : avl_i[2:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vl_q <= 3'(`VC_LANES);            // full length out of reset
        end else if (cfg_we_i) begin
            vl_q <= vl_clamp;
        end
    end

    assign vl_o = vl_q;

    always_comb begin
        for (int i = 0; i < `VC_LANES; i++) begin
            emask_o[i] = (i < vl_q);         // low vl lanes active
        end
    end

endmodule

// File: verilog/vid.sv
////////////////////////////////////////
// decode and issue
// pops the queue and steers vex, vlsu and vcsrs
////////////////////////////////////////
`timescale 1ns/1ns
`include "vcore_params.svh"

module vid (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  empty_i,
    input  vcore_pkg::inst_u      head_i,
    input  logic                  vlsu_done_i,
    output logic                  pop_o,
    output vcore_pkg::vreg_addr_t vs1_addr_o,
    output vcore_pkg::vreg_addr_t vs2_addr_o,
    output vcore_pkg::vreg_addr_t vd_addr_o,
    output logic                  ex_issue_o,
    output vcore_pkg::vex_op_e    ex_op_o,
    output logic                  ex_use_imm_o,
    output logic [4:0]            ex_imm_o,
    output logic                  ls_issue_o,
    output logic                  ls_store_o,
    output logic [11:0]           ls_base_o,
    output logic                  cfg_we_o,
    output logic [11:0]           avl_o
);
    import vcore_pkg::*;

    logic [6:0] opc;
    logic       funct_ok;
    logic       is_mem;
    logic       bubble_q;                    // cycle after an arith issue
    logic       busy_q;                      // load/store in flight

    assign opc = head_i.arith.opcode;

    ////////////////////////////////////////
    // field decode

    always_comb begin
        funct_ok = 1'b1;
        case (head_i.arith.funct)
            `VC_F_ADD: ex_op_o = ADD;
            `VC_F_SUB: ex_op_o = SUB;
            `VC_F_MUL: ex_op_o = MUL;
            `VC_F_AND: ex_op_o = AND;
            default: begin
                ex_op_o  = ADD;
                funct_ok = 1'b0;             // bad funct is dropped
            end
        endcase
    end

    assign vs1_addr_o   = head_i.arith.vs1;
    assign vs2_addr_o   = head_i.arith.vs2;
    assign vd_addr_o    = head_i.arith.vd;   // same bits in the memory view
    assign ex_use_imm_o = head_i.arith.use_imm;
    assign ex_imm_o     = head_i.arith.vs1;
    assign ls_base_o    = head_i.mem.base;
    assign avl_o        = head_i.cfg.avl;

    ////////////////////////////////////////
    // issue

    assign is_mem     = (opc == `VC_OPC_LOAD) || (opc == `VC_OPC_STORE);
    assign pop_o      = !empty_i && !bubble_q && !busy_q;
    assign ex_issue_o = pop_o && (opc == `VC_OPC_ARITH) && funct_ok;
    assign ls_issue_o = pop_o && is_mem;
    assign ls_store_o = (opc == `VC_OPC_STORE);
    assign cfg_we_o   = pop_o && (opc == `VC_OPC_CFG);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bubble_q <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            bubble_q <= ex_issue_o;          // lets the writeback land first
            if (ls_issue_o) begin
                busy_q <= 1'b1;
            end else if (vlsu_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/vrf.sv
////////////////////////////////////////
// vector register file
// 32 x 128, masked element write
////////////////////////////////////////
`timescale 1ns/1ns
`include "vcore_params.svh"

module vrf (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  vcore_pkg::vreg_addr_t vs1_addr_i,
    input  vcore_pkg::vreg_addr_t vs2_addr_i,
    input  vcore_pkg::vreg_addr_t vs3_addr_i,
    input  logic                  we_i,
    input  vcore_pkg::emask_t     wmask_i,
    input  vcore_pkg::vreg_addr_t waddr_i,
    input  vcore_pkg::vreg_t      wdata_i,
    output vcore_pkg::vreg_t      vs1_data_o,
    output vcore_pkg::vreg_t      vs2_data_o,
    output vcore_pkg::vreg_t      vs3_data_o
);
    import vcore_pkg::*;

    vreg_t regs_q [`VC_NREGS];

    // asynchronous read
    assign vs1_data_o = regs_q[vs1_addr_i];
    assign vs2_data_o = regs_q[vs2_addr_i];
    assign vs3_data_o = regs_q[vs3_addr_i]; // store data

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `VC_NREGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (we_i) begin
            for (int i = 0; i < `VC_LANES; i++) begin
                if (wmask_i[i]) begin
                    regs_q[waddr_i][i] <= wdata_i[i]; // tail left alone
                end
            end
        end
    end

endmodule

// File: verilog/vex.sv
////////////////////////////////////////
// vector execute
// four lanes, result registered for writeback
////////////////////////////////////////
`timescale 1ns/1ns
`include "vcore_params.svh"

module vex (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  issue_i,
    input  vcore_pkg::vex_op_e    op_i,
    input  logic                  use_imm_i,
    input  logic [4:0]            imm_i,
    input  vcore_pkg::vreg_addr_t vd_i,
    input  vcore_pkg::vreg_t      vs1_data_i,
    input  vcore_pkg::vreg_t      vs2_data_i,
    input  vcore_pkg::emask_t     emask_i,
    output logic                  wb_valid_o,
    output vcore_pkg::vreg_addr_t wb_addr_o,
    output vcore_pkg::emask_t     wb_mask_o,
    output vcore_pkg::vreg_t      wb_data_o
);
    import vcore_pkg::*;

    elem_t imm_ext;
    vreg_t res_c;

    function automatic elem_t lane_op(vex_op_e op, elem_t a, elem_t b);
        case (op)
            ADD:     return a + b;           // wraps in 32 bits
            SUB:     return a - b;
            MUL:     return a * b;           // low half only
            default: return a & b;
        endcase
    endfunction

    assign imm_ext = {{27{imm_i[4]}}, imm_i};

    for (genvar i = 0; i < `VC_LANES; i++) begin : g_lane
        elem_t opb;
        assign opb      = use_imm_i ? imm_ext : vs1_data_i[i];
        assign res_c[i] = lane_op(op_i, vs2_data_i[i], opb); // vs2 op vs1/imm
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= issue_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            wb_data_o <= res_c;
            wb_addr_o <= vd_i;
            wb_mask_o <= emask_i;            // vl at issue time
        end
    end

endmodule

// File: verilog/vlsu.sv
////////////////////////////////////////
// vector load/store sequencer
// one word per memory request, up to vl words
////////////////////////////////////////
`timescale 1ns/1ns
`include "vcore_params.svh"

module vlsu (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  issue_i,
    input  logic                  store_i,
    input  logic [11:0]           base_i,
    input  vcore_pkg::vreg_addr_t vd_i,
    input  logic [2:0]            vl_i,
    input  vcore_pkg::emask_t     emask_i,
    input  vcore_pkg::vreg_t      st_data_i,
    input  logic                  mem_ack_i,
    input  vcore_pkg::elem_t      mem_rdata_i,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [11:0]           mem_addr_o,
    output vcore_pkg::elem_t      mem_wdata_o,
    output logic                  done_o,
    output logic                  wb_valid_o,
    output vcore_pkg::vreg_addr_t wb_addr_o,
    output vcore_pkg::emask_t     wb_mask_o,
    output vcore_pkg::vreg_t      wb_data_o
);
    import vcore_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } ls_state_e;

    ls_state_e   state_q;
    logic [1:0]  idx_q;                      // element index
    logic        store_q;
    logic        done_q;
    logic        last;
    logic [11:0] base_q;
    logic [2:0]  vl_q;
    vreg_addr_t  vd_q;
    emask_t      mask_q;
    vreg_t       sdata_q;
    vreg_t       ldata_q;

    assign last = ({1'b0, idx_q} == vl_q - 3'd1);

    ////////////////////////////////////////
    // sequencer

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            idx_q   <= '0;
            store_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (issue_i) begin
                        store_q <= store_i;
                        idx_q   <= '0;
                        if (vl_i == 3'd0) begin
                            done_q <= 1'b1;  // nothing to move
                        end else begin
                            state_q <= S_REQ;
                        end
                    end
                end
                S_REQ: state_q <= S_WAIT;    // single-cycle request pulse
                S_WAIT: begin
                    if (mem_ack_i) begin
                        if (last) begin
                            done_q  <= 1'b1;
                            state_q <= S_IDLE;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            state_q <= S_REQ;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // operands held for the whole transfer
    always_ff @(posedge clk) begin
        if (issue_i && state_q == S_IDLE) begin
            base_q  <= base_i;
            vl_q    <= vl_i;
            vd_q    <= vd_i;
            mask_q  <= emask_i;
            sdata_q <= st_data_i;
        end
        if (state_q == S_WAIT && mem_ack_i && !store_q) begin
            ldata_q[idx_q] <= mem_rdata_i;   // gather load words
        end
    end

    ////////////////////////////////////////
    // memory port and writeback

    assign mem_req_o   = (state_q == S_REQ);
    assign mem_we_o    = mem_req_o && store_q;
    assign mem_addr_o  = base_q + {8'd0, idx_q, 2'b00};
    assign mem_wdata_o = sdata_q[idx_q];

    assign done_o     = done_q;
    assign wb_valid_o = done_q && !store_q;  // loads write vd once at the end
    assign wb_addr_o  = vd_q;
    assign wb_mask_o  = mask_q;
    assign wb_data_o  = ldata_q;

endmodule

// File: verilog/vcore_top.sv
////////////////////////////////////////
// vector core top
////////////////////////////////////////
`timescale 1ns/1ns

module vcore_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  vcore_pkg::inst_u  inst_i,
    output logic              inst_credit_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output logic [11:0]       mem_addr_o,
    output vcore_pkg::elem_t  mem_wdata_o,
    input  logic              mem_ack_i,
    input  vcore_pkg::elem_t  mem_rdata_i
);
    import vcore_pkg::*;

    ////////////////////////////////////////
    // internal wires

    logic        q_empty;
    inst_u       q_head;
    logic        id_pop;
    vreg_addr_t  id_vs1_addr;
    vreg_addr_t  id_vs2_addr;
    vreg_addr_t  id_vd_addr;
    logic        id_ex_issue;
    vex_op_e     id_ex_op;
    logic        id_use_imm;
    logic [4:0]  id_imm;
    logic        id_ls_issue;
    logic        id_ls_store;
    logic [11:0] id_ls_base;
    logic        id_cfg_we;
    logic [11:0] id_avl;
    logic [2:0]  vl;
    emask_t      emask;
    vreg_t       vs1_data;
    vreg_t       vs2_data;
    vreg_t       vs3_data;
    logic        ex_wb_valid;
    vreg_addr_t  ex_wb_addr;
    emask_t      ex_wb_mask;
    vreg_t       ex_wb_data;
    logic        ls_done;
    logic        ls_wb_valid;
    vreg_addr_t  ls_wb_addr;
    emask_t      ls_wb_mask;
    vreg_t       ls_wb_data;
    logic        wr_en;
    vreg_addr_t  wr_addr;
    emask_t      wr_mask;
    vreg_t       wr_data;

    // writeback mux, vex and vlsu never write in the same cycle
    assign wr_en   = ex_wb_valid | ls_wb_valid;
    assign wr_addr = ex_wb_valid ? ex_wb_addr : ls_wb_addr;
    assign wr_mask = ex_wb_valid ? ex_wb_mask : ls_wb_mask;
    assign wr_data = ex_wb_valid ? ex_wb_data : ls_wb_data;

    ////////////////////////////////////////
    // blocks

    inst_queue u_inst_queue (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .pop_i         (id_pop),
        .empty_o       (q_empty),
        .head_o        (q_head),
        .inst_credit_o (inst_credit_o)
    );

    vcsrs u_vcsrs (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .cfg_we_i (id_cfg_we),
        .avl_i    (id_avl),
        .vl_o     (vl),
        .emask_o  (emask)
    );

    vid u_vid (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .empty_i      (q_empty),
        .head_i       (q_head),
        .vlsu_done_i  (ls_done),
        .pop_o        (id_pop),
        .vs1_addr_o   (id_vs1_addr),
        .vs2_addr_o   (id_vs2_addr),
        .vd_addr_o    (id_vd_addr),
        .ex_issue_o   (id_ex_issue),
        .ex_op_o      (id_ex_op),
        .ex_use_imm_o (id_use_imm),
        .ex_imm_o     (id_imm),
        .ls_issue_o   (id_ls_issue),
        .ls_store_o   (id_ls_store),
        .ls_base_o    (id_ls_base),
        .cfg_we_o     (id_cfg_we),
        .avl_o        (id_avl)
    );

    vrf u_vrf (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .vs1_addr_i (id_vs1_addr),
        .vs2_addr_i (id_vs2_addr),
        .vs3_addr_i (id_vd_addr),            // store source is vd
        .we_i       (wr_en),
        .wmask_i    (wr_mask),
        .waddr_i    (wr_addr),
        .wdata_i    (wr_data),
        .vs1_data_o (vs1_data),
        .vs2_data_o (vs2_data),
        .vs3_data_o (vs3_data)
    );

    vex u_vex (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .issue_i    (id_ex_issue),
        .op_i       (id_ex_op),
        .use_imm_i  (id_use_imm),
        .imm_i      (id_imm),
        .vd_i       (id_vd_addr),
        .vs1_data_i (vs1_data),
        .vs2_data_i (vs2_data),
        .emask_i    (emask),
        .wb_valid_o (ex_wb_valid),
        .wb_addr_o  (ex_wb_addr),
        .wb_mask_o  (ex_wb_mask),
        .wb_data_o  (ex_wb_data)
    );

    vlsu u_vlsu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .issue_i     (id_ls_issue),
        .store_i     (id_ls_store),
        .base_i      (id_ls_base),
        .vd_i        (id_vd_addr),
        .vl_i        (vl),
        .emask_i     (emask),
        .st_data_i   (vs3_data),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .done_o      (ls_done),
        .wb_valid_o  (ls_wb_valid),
        .wb_addr_o   (ls_wb_addr),
        .wb_mask_o   (ls_wb_mask),
        .wb_data_o   (ls_wb_data)
    );

endmodule

// File: dv/vcore_tb.sv
////////////////////////////////////////
// vector core testbench
// credit sender, memory model, reference model
////////////////////////////////////////
`timescale 1ns/1ns
`include "vcore_params.svh"

module vcore_tb;
    import vcore_pkg::*;

    localparam int TMO = 2000;               // cycles per wait loop

    logic        clk;
    logic        rst_n_i;
    logic        inst_valid_i;
    inst_u       inst_i;
    logic        inst_credit_o;
    logic        mem_req_o;
    logic        mem_we_o;
    logic [11:0] mem_addr_o;
    elem_t       mem_wdata_o;
    logic        mem_ack_i;
    elem_t       mem_rdata_i;

    int          credits;
    int          errors;
    int          timeouts;
    logic        req_pending;                // request sent and not yet acked
    logic [31:0] lfsr_state;
    logic [31:0] mem [1024];
    logic [31:0] ref_mem [1024];
    logic [31:0] ref_regs [32][4];
    int          ref_vl;
    logic [44:0] exp_q [$];                  // {we, addr, data} in program order

    vcore_top DUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .inst_credit_o (inst_credit_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [9:0] a);
        return {6'h2b, a, ~a, a[5:0]};
    endfunction

    function automatic logic [31:0] ref_op(input logic [3:0] funct, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [63:0] prod;
        prod = a * b;
        case (funct)
            `VC_F_ADD: return a + b;
            `VC_F_SUB: return a - b;
            `VC_F_MUL: return prod[31:0];     // low word of product
            default:   return a & b;
        endcase
    endfunction

    task automatic send(input logic [31:0] w);
        int t;
        t = 0;
        if (timeouts != 0) begin
            return;
        end
        while (credits == 0 && t < TMO) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (credits == 0) begin
            timeouts++;
            $display("timed out at %0t ns waiting for an instruction credit", $time);
        end else begin
            inst_valid_i = 1'b1;
            inst_i       = w;
            @(posedge clk);
            #2;
            inst_valid_i = 1'b0;
        end
    endtask

    task automatic issue_cfg(input logic [11:0] avl);
        ref_vl = (avl > 12'd4) ? 4 : int'(avl);
        send({avl, 13'h0, `VC_OPC_CFG});
    endtask

    task automatic issue_load(input logic [4:0] vd, input logic [11:0] base);
        logic [11:0] a;
        for (int i = 0; i < ref_vl; i++) begin
            a = base + 12'(4 * i);
            exp_q.push_back({1'b0, a, 32'h0});
            ref_regs[vd][i] = ref_mem[a[11:2]];
        end
        send({base, 8'h00, vd, `VC_OPC_LOAD});
    endtask

    task automatic issue_store(input logic [4:0] vd, input logic [11:0] base);
        logic [11:0] a;
        for (int i = 0; i < ref_vl; i++) begin
            a = base + 12'(4 * i);
            exp_q.push_back({1'b1, a, ref_regs[vd][i]});
            ref_mem[a[11:2]] = ref_regs[vd][i];
        end
        send({base, 8'h00, vd, `VC_OPC_STORE});
    endtask

    task automatic issue_arith(input logic [3:0] funct, input logic [4:0] vd, vs2, src,
                               input logic use_imm);
        logic [31:0] b;
        for (int i = 0; i < ref_vl; i++) begin
            b = use_imm ? {{27{src[4]}}, src} : ref_regs[src][i];
            ref_regs[vd][i] = ref_op(funct, ref_regs[vs2][i], b);
        end
        send({2'b00, funct, use_imm, vs2, src, 3'b000, vd, `VC_OPC_ARITH});
    endtask

    task automatic check_request(input logic we, input logic [11:0] addr,
                                 input logic [31:0] wdata);
        logic [44:0] e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("memory request at %0t ns to %h with none expected", $time, addr);
        end else begin
            e = exp_q.pop_front();
            assert (we == e[44] && addr == e[43:32] && (!we || wdata == e[31:0])) else begin
                errors++;
                $display("[FAIL] %0t ns: request we=%0b addr=%h data=%h, expected %0b %h %h",
                         $time, we, addr, wdata, e[44], e[43:32], e[31:0]);
            end
        end
    endtask

    ////////////////////////////////////////
    // credit count and memory model

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits     <= `VC_QDEPTH;
            req_pending <= 1'b0;
        end else begin
            credits <= credits - int'(inst_valid_i) + int'(inst_credit_o);
            if (mem_req_o) begin
                req_pending <= 1'b1;
            end else if (mem_ack_i) begin
                req_pending <= 1'b0;
            end
        end
    end

    always begin : mem_model
        logic [31:0] dly;
        logic        we;
        logic [11:0] addr;
        logic [31:0] wdata;
        @(posedge clk);
        if (rst_n_i && mem_req_o) begin
            we    = mem_we_o;
            addr  = mem_addr_o;
            wdata = mem_wdata_o;
            check_request(we, addr, wdata);
            draw_bits(2, dly);
            repeat (dly[1:0]) @(posedge clk);   // ack after 1 to 4 cycles
            #2;
            mem_rdata_i = mem[addr[11:2]];
            if (we) begin
                mem[addr[11:2]] = wdata;
            end
            mem_ack_i = 1'b1;
            @(posedge clk);
            #2;
            mem_ack_i = 1'b0;
        end
    end

    ////////////////////////////////////////
    // assertions

    credit_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        credits >= 0 && credits <= `VC_QDEPTH)
        else begin
            errors++;
            $display("[FAIL] %0t ns: credit count %0d out of range", $time, credits);
        end

    credit_at_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_credit_o |-> credits < `VC_QDEPTH)
        else begin
            errors++;
            $display("[FAIL] %0t ns: credit returned with all credits held", $time);
        end

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_o |-> !req_pending)
        else begin
            errors++;
            $display("[FAIL] %0t ns: request while another is outstanding", $time);
        end

    ////////////////////////////////////////
    // program

    initial begin : stimulus
        logic [31:0] r_funct;
        logic [31:0] r_sel;
        logic [31:0] r_src;
        logic [31:0] r_vs2;
        logic [31:0] r_vd;
        int          t;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        mem_ack_i    = 1'b0;
        mem_rdata_i  = '0;
        errors       = 0;
        timeouts     = 0;
        ref_vl       = `VC_LANES;
        lfsr_state   = 32'h2b45_5f81;
        for (int a = 0; a < 1024; a++) begin
            mem[a]     = fill_word(10'(a));
            ref_mem[a] = mem[a];
        end
        for (int r = 0; r < 32; r++) begin
            for (int i = 0; i < 4; i++) begin
                ref_regs[r][i] = '0;
            end
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        issue_load(5'd1, 12'h100);            // copy four words
        issue_store(5'd1, 12'h200);
        issue_load(5'd2, 12'h140);
        for (int f = 0; f < 4; f++) begin
            issue_arith(4'(f), 5'(3 + f), 5'd1, 5'd2, 1'b0);
            issue_arith(4'(f), 5'(7 + f), 5'd2, 5'(-3 - 4 * f), 1'b1); // negative imm
        end
        for (int v = 3; v <= 10; v++) begin
            issue_store(5'(v), 12'h210 + 12'(16 * (v - 3)));
        end

        // tail elements stay put
        issue_load(5'd11, 12'h180);
        issue_cfg(12'd2);
        issue_arith(`VC_F_ADD, 5'd11, 5'd11, 5'd2, 1'b0);
        issue_cfg(12'd9);
        issue_store(5'd11, 12'h300);

        // vl = 0 and an unknown opcode
        issue_cfg(12'd0);
        issue_load(5'd12, 12'h1c0);
        issue_store(5'd1, 12'h340);
        issue_cfg(12'd4);
        send({2'b00, `VC_F_ADD, 1'b0, 5'd1, 5'd2, 3'b000, 5'd1, 7'h7f});
        issue_store(5'd12, 12'h350);
        issue_store(5'd1, 12'h360);

        for (int k = 0; k < 6; k++) begin
            draw_bits(2, r_funct);
            draw_bits(1, r_sel);
            draw_bits(5, r_src);
            draw_bits(3, r_vs2);
            draw_bits(2, r_vd);
            issue_arith(r_funct[3:0], 5'(13 + r_vd), 5'(1 + r_vs2), r_src[4:0], r_sel[0]);
            issue_store(5'(13 + r_vd), 12'h400 + 12'(16 * k));
        end

        // drain until all credits are back and all requests seen
        t = 0;
        while ((credits != `VC_QDEPTH || exp_q.size() != 0 || req_pending) && t < TMO) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (credits != `VC_QDEPTH || exp_q.size() != 0 || req_pending) begin
            timeouts++;
            $display("timed out at %0t ns waiting for the program to drain", $time);
        end
        repeat (8) @(posedge clk);

        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verilog
verilog/vcore_pkg.sv
verilog/inst_queue.sv
verilog/vcsrs.sv
verilog/vid.sv
verilog/vrf.sv
verilog/vex.sv
verilog/vlsu.sv
verilog/vcore_top.sv
dv/vcore_tb.sv

// File: run.sh
#!/bin/sh
# build and run the vector core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vcore_tb \
    -f project.f -o vcore_sim > build.log 2>&1 &&
./obj_dir/vcore_sim > sim.log 2>&1 ||
echo "build or run error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
